// File: logic/tlb_pkg.sv
package tlb_pkg;

    // table geometry
    localparam int tlb_entries    = 16;
    localparam int tlb_data_ports = 2;

    typedef logic [$clog2(tlb_entries)-1:0] tlb_idx_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] vpn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [4:0]  inv_op_t;

    // page size exponents, only these two are legal
    localparam ps_t ps_4k = ps_t'(12);
    localparam ps_t ps_4m = ps_t'(21);

    // INVTLB op codes
    localparam inv_op_t inv_op_all            = inv_op_t'(0);
    localparam inv_op_t inv_op_all_alt        = inv_op_t'(1);
    localparam inv_op_t inv_op_glb            = inv_op_t'(2);
    localparam inv_op_t inv_op_nglb           = inv_op_t'(3);
    localparam inv_op_t inv_op_nglb_asid      = inv_op_t'(4);
    localparam inv_op_t inv_op_nglb_asid_va   = inv_op_t'(5);
    localparam inv_op_t inv_op_glb_or_asid_va = inv_op_t'(6);
    // anything above this is illegal
    localparam inv_op_t inv_op_max            = inv_op_glb_or_asid_va;

    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] plv;
        logic [1:0] mat;
        logic       d;
        logic       v;
    } tlb_page_t;

    // one entry maps an even/odd page pair
    typedef struct packed {
        vppn_t     vppn;
        asid_t     asid;
        logic      g;
        ps_t       ps;
        logic      e;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        logic  valid;
        asid_t asid;
        vpn_t  vpn;
    } tlb_s_req_t;

    typedef struct packed {
        logic      found;
        tlb_idx_t  index;
        ps_t       ps;
        tlb_page_t page;
    } tlb_s_resp_t;

    // index is ignored on a fill
    typedef struct packed {
        logic       we;
        logic       fill;
        tlb_idx_t   index;
        tlb_entry_t entry;
    } tlb_w_req_t;

    typedef struct packed {
        logic    en;
        inv_op_t op;
        asid_t   asid;
        vppn_t   vppn;
    } tlb_inv_req_t;

    // en already qualified by the op code check
    typedef struct packed {
        logic    en;
        inv_op_t op;
        asid_t   asid;
        vppn_t   vppn;
    } tlb_inv_cmd_t;

    // 4k pages compare the whole vppn, 4M pages only bits 31:23
    function automatic logic vppn_match(tlb_entry_t ent, vppn_t vppn);
        if (ent.ps == ps_4k) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:10] == vppn[18:10];
    endfunction

endpackage

// File: logic/tlb_ctrl.sv
module tlb_ctrl (
    input  logic                  clk,
    input  logic                  rst_i,
    input  tlb_pkg::tlb_w_req_t   w_req_i,
    input  tlb_pkg::tlb_inv_req_t inv_req_i,
    output logic                  wr_en_o,
    output tlb_pkg::tlb_idx_t     wr_index_o,
    output tlb_pkg::tlb_entry_t   wr_entry_o,
    output tlb_pkg::tlb_inv_cmd_t inv_cmd_o,
    output tlb_pkg::tlb_idx_t     fill_index_o,
    output logic                  inv_bad_op_o
);
    import tlb_pkg::*;

    tlb_idx_t fill_ptr_q;
    logic     fill_now;
    logic     op_legal;
    logic     bad_op_q;

    assign fill_now = w_req_i.we && w_req_i.fill;

    // write target
    assign wr_en_o    = w_req_i.we;
    assign wr_index_o = w_req_i.fill ? fill_ptr_q : w_req_i.index;
    assign wr_entry_o = w_req_i.entry;

    // round robin fill pointer, wraps naturally at 16
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fill_ptr_q <= '0;
        end else if (fill_now) begin
            fill_ptr_q <= fill_ptr_q + tlb_idx_t'(1);
        end
    end

    assign fill_index_o = fill_ptr_q;

    // op codes 0..6 only
    assign op_legal = inv_req_i.op <= inv_op_max;

    always_comb begin
        inv_cmd_o.en   = inv_req_i.en && op_legal;
        inv_cmd_o.op   = inv_req_i.op;
        inv_cmd_o.asid = inv_req_i.asid;
        inv_cmd_o.vppn = inv_req_i.vppn;
    end

    // one cycle pulse after an illegal request
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bad_op_q <= 1'b0;
        end else begin
            bad_op_q <= inv_req_i.en && !op_legal;
        end
    end

    assign inv_bad_op_o = bad_op_q;

endmodule

// File: logic/tlb_entry_array.sv
module tlb_entry_array (
    input  logic                                             clk,
    input  logic                                             rst_i,
    input  logic                                             wr_en_i,
    input  tlb_pkg::tlb_idx_t                                wr_index_i,
    input  tlb_pkg::tlb_entry_t                              wr_entry_i,
    input  logic [tlb_pkg::tlb_entries-1:0]                  clear_mask_i,
    input  tlb_pkg::tlb_idx_t                                r_index_i,
    output tlb_pkg::tlb_entry_t [tlb_pkg::tlb_entries-1:0]   entries_o,
    output tlb_pkg::tlb_entry_t                              r_entry_o
);
    import tlb_pkg::*;

    // payload fields, the e bit in here is shadowed by exist_q
    tlb_entry_t [tlb_entries-1:0] entry_q;
    logic       [tlb_entries-1:0] exist_q;
    logic       [tlb_entries-1:0] wr_hit;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            entry_q[wr_index_i] <= wr_entry_i;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            wr_hit[i] = wr_en_i && (wr_index_i == tlb_idx_t'(i));
        end
    end

    // written entry wins over the invalidate mask
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exist_q <= '0;
        end else begin
            for (int i = 0; i < tlb_entries; i++) begin
                if (wr_hit[i]) begin
                    exist_q[i] <= wr_entry_i.e;
                end else if (clear_mask_i[i]) begin
                    exist_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            entries_o[i]   = entry_q[i];
            entries_o[i].e = exist_q[i];
        end
    end

    // TLBRD
    assign r_entry_o = entries_o[r_index_i];

endmodule

// File: logic/tlb_inv_match.sv
module tlb_inv_match (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_entries-1:0] entries_i,
    input  tlb_pkg::tlb_inv_cmd_t                          inv_cmd_i,
    output logic [tlb_pkg::tlb_entries-1:0]                clear_mask_o
);
    import tlb_pkg::*;

    logic [tlb_entries-1:0] glb;
    logic [tlb_entries-1:0] asid_eq;
    logic [tlb_entries-1:0] va_eq;
    logic [tlb_entries-1:0] clr;

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            glb[i]     = entries_i[i].g;
            asid_eq[i] = entries_i[i].asid == inv_cmd_i.asid;
            va_eq[i]   = vppn_match(entries_i[i], inv_cmd_i.vppn);
        end
    end

    // one rule per op, evaluated on every entry at once
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            case (inv_cmd_i.op)
                inv_op_all, inv_op_all_alt: begin
                    clr[i] = 1'b1;
                end
                inv_op_glb: begin
                    clr[i] = glb[i];
                end
                inv_op_nglb: begin
                    clr[i] = !glb[i];
                end
                inv_op_nglb_asid: begin
                    clr[i] = !glb[i] && asid_eq[i];
                end
                inv_op_nglb_asid_va: begin
                    clr[i] = !glb[i] && asid_eq[i] && va_eq[i];
                end
                inv_op_glb_or_asid_va: begin
                    clr[i] = glb[i] || (asid_eq[i] && va_eq[i]);
                end
                default: begin
                    clr[i] = 1'b0;
                end
            endcase
        end
    end

    // nothing cleared unless the command is live
    assign clear_mask_o = inv_cmd_i.en ? clr : '0;

endmodule

// File: logic/tlb_lookup.sv
module tlb_lookup (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_entries-1:0] entries_i,
    input  tlb_pkg::tlb_s_req_t                            req_i,
    output tlb_pkg::tlb_s_resp_t                           resp_o
);
    import tlb_pkg::*;

    logic       [tlb_entries-1:0] asid_ok;
    logic       [tlb_entries-1:0] va_ok;
    logic       [tlb_entries-1:0] hit;
    tlb_idx_t                     hit_idx;
    tlb_entry_t                   hit_entry;
    vppn_t                        req_vppn;
    logic                         odd_page;

    // drop the even/odd bit
    assign req_vppn = req_i.vpn[19:1];

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            asid_ok[i] = entries_i[i].g || (entries_i[i].asid == req_i.asid);
            va_ok[i]   = vppn_match(entries_i[i], req_vppn);
            hit[i]     = entries_i[i].e && asid_ok[i] && va_ok[i];
        end
    end

    // lowest hitting index wins
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign hit_entry = entries_i[hit_idx];

    // odd page select is address bit 12 or bit 21
    always_comb begin
        if (hit_entry.ps == ps_4k) begin
            odd_page = req_i.vpn[0];
        end else begin
            odd_page = req_i.vpn[9];
        end
    end

    always_comb begin
        resp_o.found = req_i.valid && (|hit);
        resp_o.index = hit_idx;
        resp_o.ps    = hit_entry.ps;
        resp_o.page  = odd_page ? hit_entry.page1 : hit_entry.page0;
    end

endmodule

// File: logic/tlb_top.sv
module tlb_top (
    input  logic                                               clk,
    input  logic                                               rst_i,
    input  tlb_pkg::tlb_s_req_t                                s_instr_req_i,
    output tlb_pkg::tlb_s_resp_t                               s_instr_resp_o,
    input  tlb_pkg::tlb_s_req_t  [tlb_pkg::tlb_data_ports-1:0] s_data_req_i,
    output tlb_pkg::tlb_s_resp_t [tlb_pkg::tlb_data_ports-1:0] s_data_resp_o,
    input  tlb_pkg::tlb_w_req_t                                w_req_i,
    input  tlb_pkg::tlb_inv_req_t                              inv_req_i,
    input  tlb_pkg::tlb_idx_t                                  r_index_i,
    output tlb_pkg::tlb_entry_t                                r_entry_o,
    output tlb_pkg::tlb_idx_t                                  fill_index_o,
    output logic                                               inv_bad_op_o
);
    import tlb_pkg::*;

    logic                         wr_en;
    tlb_idx_t                     wr_index;
    tlb_entry_t                   wr_entry;
    tlb_inv_cmd_t                 inv_cmd;
    logic       [tlb_entries-1:0] clear_mask;
    tlb_entry_t [tlb_entries-1:0] entries;

    tlb_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .w_req_i      (w_req_i),
        .inv_req_i    (inv_req_i),
        .wr_en_o      (wr_en),
        .wr_index_o   (wr_index),
        .wr_entry_o   (wr_entry),
        .inv_cmd_o    (inv_cmd),
        .fill_index_o (fill_index_o),
        .inv_bad_op_o (inv_bad_op_o)
    );

    tlb_entry_array u_array (
        .clk          (clk),
        .rst_i        (rst_i),
        .wr_en_i      (wr_en),
        .wr_index_i   (wr_index),
        .wr_entry_i   (wr_entry),
        .clear_mask_i (clear_mask),
        .r_index_i    (r_index_i),
        .entries_o    (entries),
        .r_entry_o    (r_entry_o)
    );

    tlb_inv_match u_inv_match (
        .entries_i    (entries),
        .inv_cmd_i    (inv_cmd),
        .clear_mask_o (clear_mask)
    );

    tlb_lookup u_lookup_instr (
        .entries_i (entries),
        .req_i     (s_instr_req_i),
        .resp_o    (s_instr_resp_o)
    );

    // one search port per data pipe
    for (genvar p = 0; p < tlb_data_ports; p++) begin : g_data_port
        tlb_lookup u_lookup_data (
            .entries_i (entries),
            .req_i     (s_data_req_i[p]),
            .resp_o    (s_data_resp_o[p])
        );
    end

endmodule

// File: bench/tlb_checker.sv
module tlb_checker (
    input logic                                               clk,
    input logic                                               rst_i,
    input tlb_pkg::tlb_s_req_t                                s_instr_req_i,
    input tlb_pkg::tlb_s_resp_t                               s_instr_resp_o,
    input tlb_pkg::tlb_s_req_t  [tlb_pkg::tlb_data_ports-1:0] s_data_req_i,
    input tlb_pkg::tlb_s_resp_t [tlb_pkg::tlb_data_ports-1:0] s_data_resp_o,
    input tlb_pkg::tlb_w_req_t                                w_req_i,
    input tlb_pkg::tlb_inv_req_t                              inv_req_i,
    input tlb_pkg::tlb_idx_t                                  fill_index_o,
    input logic                                               inv_bad_op_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import tlb_pkg::*;

    tlb_entry_t             model_q [tlb_entries];
    logic [tlb_entries-1:0] exist_q;
    tlb_idx_t               fill_q;
    tlb_idx_t               widx;
    logic [2:0]             port_ok;
    int                     fail_cnt = 0;

    function automatic logic vppn_hit(tlb_entry_t ent, vppn_t vppn);
        if (ent.ps == 6'd12) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:10] == vppn[18:10];
    endfunction

    function automatic logic inv_hit(tlb_entry_t ent, tlb_inv_req_t inv);
        case (inv.op)
            5'd0, 5'd1: return 1'b1;
            5'd2: return ent.g;
            5'd3: return !ent.g;
            5'd4: return !ent.g && ent.asid == inv.asid;
            5'd5: return !ent.g && ent.asid == inv.asid && vppn_hit(ent, inv.vppn);
            5'd6: return ent.g || (ent.asid == inv.asid && vppn_hit(ent, inv.vppn));
            default: return 1'b0;
        endcase
    endfunction

    // lowest hitting index wins
    function automatic logic resp_ok(tlb_s_req_t req, tlb_s_resp_t resp);
        tlb_entry_t ent;
        logic       odd;
        for (int i = 0; i < tlb_entries; i++) begin
            ent = model_q[i];
            if (exist_q[i] && (ent.g || ent.asid == req.asid) && vppn_hit(ent, req.vpn[19:1])) begin
                odd = (ent.ps == 6'd12) ? req.vpn[0] : req.vpn[9];
                return req.valid == resp.found && (!req.valid ||
                    (resp.index == tlb_idx_t'(i) && resp.ps == ent.ps &&
                     resp.page == (odd ? ent.page1 : ent.page0)));
            end
        end
        return !resp.found;
    endfunction

    assign widx = w_req_i.fill ? fill_q : w_req_i.index;

    // per port verdict against the model before the edge
    always_comb begin
        port_ok[0] = resp_ok(s_instr_req_i, s_instr_resp_o);
        port_ok[1] = resp_ok(s_data_req_i[0], s_data_resp_o[0]);
        port_ok[2] = resp_ok(s_data_req_i[1], s_data_resp_o[1]);
    end

    always @(posedge clk) begin
        if (rst_i) begin
            exist_q <= '0;
            fill_q  <= '0;
        end else begin
            for (int i = 0; i < tlb_entries; i++) begin
                if (w_req_i.we && widx == tlb_idx_t'(i)) begin
                    model_q[i] <= w_req_i.entry;
                    exist_q[i] <= w_req_i.entry.e;
                end else if (inv_req_i.en && inv_hit(model_q[i], inv_req_i)) begin
                    exist_q[i] <= 1'b0;
                end
            end
            if (w_req_i.we && w_req_i.fill) begin
                fill_q <= fill_q + 4'd1;
            end
        end
    end

    a_instr: assert property (@(posedge clk) disable iff (rst_i) port_ok[0])
        else begin
            fail_cnt++;
            $error("ERROR s_instr_resp_o got %h for request %h",
                   $sampled(s_instr_resp_o), $sampled(s_instr_req_i));
        end
    a_data0: assert property (@(posedge clk) disable iff (rst_i) port_ok[1])
        else begin
            fail_cnt++;
            $error("ERROR s_data_resp_o[0] got %h for request %h",
                   $sampled(s_data_resp_o[0]), $sampled(s_data_req_i[0]));
        end
    a_data1: assert property (@(posedge clk) disable iff (rst_i) port_ok[2])
        else begin
            fail_cnt++;
            $error("ERROR s_data_resp_o[1] got %h for request %h",
                   $sampled(s_data_resp_o[1]), $sampled(s_data_req_i[1]));
        end
    a_fill: assert property (@(posedge clk) disable iff (rst_i) fill_index_o == fill_q)
        else begin
            fail_cnt++;
            $error("ERROR fill_index_o got %h expected %h",
                   $sampled(fill_index_o), $sampled(fill_q));
        end
    a_bad_op: assert property (@(posedge clk) disable iff (rst_i)
        inv_bad_op_o == $past(inv_req_i.en && inv_req_i.op > 5'd6))
        else begin
            fail_cnt++;
            $error("ERROR inv_bad_op_o got %h expected %h",
                   $sampled(inv_bad_op_o), !$sampled(inv_bad_op_o));
        end

endmodule

bind tlb_top tlb_checker u_checker (
    .clk            (clk),
    .rst_i          (rst_i),
    .s_instr_req_i  (s_instr_req_i),
    .s_instr_resp_o (s_instr_resp_o),
    .s_data_req_i   (s_data_req_i),
    .s_data_resp_o  (s_data_resp_o),
    .w_req_i        (w_req_i),
    .inv_req_i      (inv_req_i),
    .fill_index_o   (fill_index_o),
    .inv_bad_op_o   (inv_bad_op_o)
);

// File: bench/tlb_tb.sv
module tlb_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import tlb_pkg::*;

    logic                                clk;
    logic                                rst_i;
    tlb_s_req_t                          s_instr_req_i;
    tlb_s_resp_t                         s_instr_resp_o;
    tlb_s_req_t  [tlb_data_ports-1:0]    s_data_req_i;
    tlb_s_resp_t [tlb_data_ports-1:0]    s_data_resp_o;
    tlb_w_req_t                          w_req_i;
    tlb_inv_req_t                        inv_req_i;
    tlb_idx_t                            r_index_i;
    tlb_entry_t                          r_entry_o;
    tlb_idx_t                            fill_index_o;
    logic                                inv_bad_op_o;

    tlb_entry_t             shadow [tlb_entries];
    logic [tlb_entries-1:0] written;
    tlb_idx_t               shadow_fill;
    int                     errors = 0;
    int                     total;

    tlb_top u_dut (.*);

    always #50 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic logic page_pair_match(tlb_entry_t ent, vppn_t vppn);
        if (ent.ps == 6'd12) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:10] == vppn[18:10];
    endfunction

    function automatic logic inv_clears(tlb_entry_t ent, tlb_inv_req_t inv);
        case (inv.op)
            5'd0, 5'd1: return 1'b1;
            5'd2: return ent.g;
            5'd3: return !ent.g;
            5'd4: return !ent.g && ent.asid == inv.asid;
            5'd5: return !ent.g && ent.asid == inv.asid && page_pair_match(ent, inv.vppn);
            5'd6: return ent.g || (ent.asid == inv.asid && page_pair_match(ent, inv.vppn));
            default: return 1'b0;
        endcase
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t ent;
        ent       = '0;
        ent.vppn  = vppn_t'($urandom);
        ent.asid  = asid_t'($urandom_range(1, 3));
        ent.g     = ($urandom_range(0, 3) == 0);
        ent.ps    = $urandom_range(0, 1) ? 6'd21 : 6'd12;
        ent.e     = 1'b1;
        ent.page0 = tlb_page_t'($urandom);
        ent.page1 = tlb_page_t'($urandom);
        return ent;
    endfunction

    task automatic write_entry(tlb_idx_t idx, tlb_entry_t ent, logic fill);
        tlb_idx_t target;
        target        = fill ? shadow_fill : idx;
        w_req_i.we    = 1'b1;
        w_req_i.fill  = fill;
        w_req_i.index = idx;
        w_req_i.entry = ent;
        step();
        w_req_i.we      = 1'b0;
        shadow[target]  = ent;
        written[target] = 1'b1;
        if (fill) begin
            shadow_fill = shadow_fill + 4'd1;
        end
    endtask

    task automatic fill_table();
        for (int i = 0; i < tlb_entries; i++) begin
            write_entry(tlb_idx_t'(i), rand_entry(), 1'b0);
        end
    endtask

    task automatic wait_fill_index(tlb_idx_t expected);
        int cnt;
        cnt = 0;
        while (fill_index_o !== expected && cnt < 20) begin
            step();
            cnt++;
        end
        if (fill_index_o !== expected) begin
            errors++;
            $display("timed out waiting for the fill index to reach %0d", expected);
        end
    endtask

    task automatic check_readback();
        for (int i = 0; i < tlb_entries; i++) begin
            r_index_i = tlb_idx_t'(i);
            @(negedge clk);
            if (written[i]) begin
                assert (r_entry_o == shadow[i]) else begin
                    errors++;
                    $display("ERROR r_entry_o[%0d] got %h expected %h", i, r_entry_o, shadow[i]);
                end
            end else begin
                assert (r_entry_o.e == shadow[i].e) else begin
                    errors++;
                    $display("ERROR r_entry_o.e[%0d] got %h expected %h", i, r_entry_o.e,
                             shadow[i].e);
                end
            end
            step();
        end
    endtask

    // near misses come from real entries with a random asid or odd bit
    function automatic tlb_s_req_t rand_req();
        tlb_s_req_t req;
        tlb_entry_t ent;
        ent       = shadow[$urandom_range(0, tlb_entries - 1)];
        req.valid = ($urandom_range(0, 7) != 0);
        req.asid  = $urandom_range(0, 1) ? ent.asid : asid_t'($urandom_range(1, 3));
        if ($urandom_range(0, 5) == 0) begin
            req.vpn = vpn_t'($urandom);
        end else if (ent.ps == 6'd12) begin
            req.vpn = {ent.vppn, 1'($urandom)};
        end else begin
            req.vpn = {ent.vppn[18:10], 11'($urandom)};
        end
        return req;
    endfunction

    task automatic search_random(int n);
        repeat (n) begin
            s_instr_req_i   = rand_req();
            s_data_req_i[0] = rand_req();
            s_data_req_i[1] = rand_req();
            step();
        end
    endtask

    task automatic invalidate(inv_op_t op, asid_t asid, vppn_t vppn);
        logic bad;
        bad            = op > 5'd6;
        inv_req_i.en   = 1'b1;
        inv_req_i.op   = op;
        inv_req_i.asid = asid;
        inv_req_i.vppn = vppn;
        for (int i = 0; i < tlb_entries; i++) begin
            if (inv_clears(shadow[i], inv_req_i)) begin
                shadow[i].e = 1'b0;
            end
        end
        step();
        inv_req_i.en = 1'b0;
        assert (inv_bad_op_o == bad) else begin
            errors++;
            $display("ERROR inv_bad_op_o got %h expected %h", inv_bad_op_o, bad);
        end
        step();
        assert (inv_bad_op_o == 1'b0) else begin
            errors++;
            $display("ERROR inv_bad_op_o got %h expected 0", inv_bad_op_o);
        end
    endtask

    initial begin
        tlb_entry_t ent;
        void'($urandom(32'h4f6f5716));
        clk = 0;
        rst_i = 1;
        s_instr_req_i = '0;
        s_data_req_i = '0;
        w_req_i = '0;
        inv_req_i = '0;
        r_index_i = '0;
        written = '0;
        shadow_fill = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #10;
        rst_i = 0;

        // empty table after reset
        search_random(8);
        assert (fill_index_o == 4'd0) else begin
            errors++;
            $display("ERROR fill_index_o got %h expected 0", fill_index_o);
        end
        check_readback();

        // fills and the wrap after 16
        for (int i = 0; i < 18; i++) begin
            wait_fill_index(tlb_idx_t'(i));
            write_entry('0, rand_entry(), 1'b1);
        end
        wait_fill_index(4'd2);
        check_readback();

        fill_table();
        check_readback();
        search_random(60);

        for (int op = 0; op <= 6; op++) begin
            fill_table();
            ent = shadow[$urandom_range(0, tlb_entries - 1)];
            invalidate(inv_op_t'(op), ent.asid, ent.vppn);
            check_readback();
            search_random(12);
        end

        fill_table();
        invalidate(5'd7, 10'd1, '0);
        invalidate(5'd31, 10'd2, '0);
        check_readback();

        // write and clear-all in one cycle
        fill_table();
        ent            = rand_entry();
        w_req_i.we     = 1'b1;
        w_req_i.fill   = 1'b0;
        w_req_i.index  = 4'd5;
        w_req_i.entry  = ent;
        inv_req_i.en   = 1'b1;
        inv_req_i.op   = 5'd0;
        step();
        w_req_i.we   = 1'b0;
        inv_req_i.en = 1'b0;
        for (int i = 0; i < tlb_entries; i++) begin
            shadow[i].e = 1'b0;
        end
        shadow[5] = ent;
        check_readback();
        search_random(12);

        total = errors + u_dut.u_checker.fail_cnt;
        $display("bench errors %0d, assertion errors %0d", errors, u_dut.u_checker.fail_cnt);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
logic/tlb_pkg.sv
logic/tlb_ctrl.sv
logic/tlb_entry_array.sv
logic/tlb_inv_match.sv
logic/tlb_lookup.sv
logic/tlb_top.sv
bench/tlb_checker.sv
bench/tlb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tlb_tb -f project.f

out=$(./obj_dir/Vtlb_tb +verilator+error+limit+1000)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
